// File: filelist.f
+incdir+sim
common/rs_pkg.sv
station/rs_wakeup.sv
station/rs_slot_picker.sv
station/rs_station.sv
logic/reservation_stations.sv
sim/tb_reservation_stations.sv

// File: Bender.yml
package:
  name: reservation_stations

sources:
  - files:
      - common/rs_pkg.sv
      - station/rs_wakeup.sv
      - station/rs_slot_picker.sv
      - station/rs_station.sv
      - logic/reservation_stations.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_reservation_stations.sv

// File: sim/rs_ref_model.svh
`ifndef RS_REF_MODEL_SVH
`define RS_REF_MODEL_SVH

// mirrored station contents, row 0 add, 1 mul, 2 div
logic [7:0]    m_occ [3];
logic [7:0]    m_r1 [3];
logic [7:0]    m_r2 [3];
rs_pkg::ptag_t m_s1 [3][8];
rs_pkg::ptag_t m_s2 [3][8];
logic [20:0]   m_rest [3][8];   // dst tag, dst areg, rob index, op

function automatic int unit_depth(input int u);
    if (u == 0)
        return rs_pkg::ADD_RS_DEPTH;
    return (u == 1) ? rs_pkg::MUL_RS_DEPTH : rs_pkg::DIV_RS_DEPTH;
endfunction

// any bus with its valid up carrying this tag
function automatic logic tag_woken(input rs_pkg::ptag_t tag);
    for (int b = 0; b < 3; b++)
    begin
        if (cdb_valid[b] && cdb_tag[b] == tag)
            return 1'b1;
    end
    return 1'b0;
endfunction

// lowest flagged slot inside the station depth, -1 when none
function automatic int lowest_slot(input int u, input logic [7:0] want);
    for (int i = 0; i < unit_depth(u); i++)
    begin
        if (want[i])
            return i;
    end
    return -1;
endfunction

// slot a unit should present, -1 when it presents nothing
function automatic int expected_issue_slot(input int u);
    return lowest_slot(u, m_occ[u] & m_r1[u] & m_r2[u]);
endfunction

function automatic logic [32:0] expected_fields(input int u, input int i);
    return {m_s1[u][i], m_s2[u][i], m_rest[u][i]};
endfunction

task automatic clear_model();
    for (int u = 0; u < 3; u++)
    begin
        m_occ[u] = '0;
        m_r1[u]  = '0;
        m_r2[u]  = '0;
    end
endtask

// held operands pick up this cycle's broadcasts at the edge
task automatic model_wakeup();
    for (int u = 0; u < 3; u++)
    begin
        for (int i = 0; i < 8; i++)
        begin
            if (m_occ[u][i])
            begin
                m_r1[u][i] = m_r1[u][i] | tag_woken(m_s1[u][i]);
                m_r2[u][i] = m_r2[u][i] | tag_woken(m_s2[u][i]);
            end
        end
    end
endtask

task automatic model_insert(input int u, input int i);
    m_occ[u][i]  = 1'b1;
    m_r1[u][i]   = src1_ready | tag_woken(src1_tag);   // same-cycle broadcast counts
    m_r2[u][i]   = src2_ready | tag_woken(src2_tag);
    m_s1[u][i]   = src1_tag;
    m_s2[u][i]   = src2_tag;
    m_rest[u][i] = {dst_tag, dst_areg, rob_idx, op};
endtask

`endif

// File: sim/tb_reservation_stations.sv
module tb_reservation_stations;

    localparam int directed_cycles = 300;
    localparam int random_cycles   = 2000;
    localparam int drain_cycles    = 100;
    localparam int cycle_limit     = 2 * (directed_cycles + random_cycles + drain_cycles);

    logic             clk;
    logic             rst;
    logic             dispatch_valid;
    logic             dispatch_ready;
    rs_pkg::rs_unit_e dispatch_unit;
    rs_pkg::ptag_t    src1_tag;
    rs_pkg::ptag_t    src2_tag;
    logic             src1_ready;
    logic             src2_ready;
    rs_pkg::ptag_t    dst_tag;
    rs_pkg::areg_t    dst_areg;
    rs_pkg::rob_idx_t rob_idx;
    rs_pkg::op_t      op;
    logic [2:0]       cdb_valid;        // add, mul, div
    rs_pkg::ptag_t    cdb_tag [3];
    logic [2:0]       iss_valid;        // indexed by unit
    logic [2:0]       iss_ready;
    rs_pkg::ptag_t    iss_src1 [3];
    rs_pkg::ptag_t    iss_src2 [3];
    rs_pkg::ptag_t    iss_dst [3];
    rs_pkg::areg_t    iss_areg [3];
    rs_pkg::rob_idx_t iss_rob [3];
    rs_pkg::op_t      iss_op [3];

    string cur_test;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_bad;
    int    cycles;
    int    dispatched;
    int    issued;
    int    next_rob;
    logic  live [64];                   // rob indices held in some station

    reservation_stations dut (
        .clk (clk), .rst (rst),
        .dispatch_valid (dispatch_valid), .dispatch_ready (dispatch_ready),
        .dispatch_unit (dispatch_unit),
        .src1_tag (src1_tag), .src2_tag (src2_tag),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .dst_tag (dst_tag), .dst_areg (dst_areg), .rob_idx (rob_idx), .op (op),
        .cdb_valid_add (cdb_valid[0]), .cdb_tag_add (cdb_tag[0]),
        .cdb_valid_mul (cdb_valid[1]), .cdb_tag_mul (cdb_tag[1]),
        .cdb_valid_div (cdb_valid[2]), .cdb_tag_div (cdb_tag[2]),
        .add_issue_valid (iss_valid[0]), .add_issue_ready (iss_ready[0]),
        .add_src1_tag (iss_src1[0]), .add_src2_tag (iss_src2[0]), .add_dst_tag (iss_dst[0]),
        .add_dst_areg (iss_areg[0]), .add_rob_idx (iss_rob[0]), .add_op (iss_op[0]),
        .mul_issue_valid (iss_valid[1]), .mul_issue_ready (iss_ready[1]),
        .mul_src1_tag (iss_src1[1]), .mul_src2_tag (iss_src2[1]), .mul_dst_tag (iss_dst[1]),
        .mul_dst_areg (iss_areg[1]), .mul_rob_idx (iss_rob[1]), .mul_op (iss_op[1]),
        .div_issue_valid (iss_valid[2]), .div_issue_ready (iss_ready[2]),
        .div_src1_tag (iss_src1[2]), .div_src2_tag (iss_src2[2]), .div_dst_tag (iss_dst[2]),
        .div_dst_areg (iss_areg[2]), .div_rob_idx (iss_rob[2]), .div_op (iss_op[2])
    );

    `include "rs_ref_model.svh"

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("tests failed");
        $finish;
    end

    function automatic logic [32:0] issue_fields(input int u);
        return {iss_src1[u], iss_src2[u], iss_dst[u], iss_areg[u], iss_rob[u], iss_op[u]};
    endfunction

    // compare between edges, then carry the model across the coming edge
    initial
    begin
        int   slot [3];
        int   u_in;
        int   free_slot;
        logic exp_ready;
        forever
        begin
            @(negedge clk);
            #1;
            if (rst)
            begin
                clear_model();
            end
            else
            begin
                for (int u = 0; u < 3; u++)
                begin
                    slot[u] = expected_issue_slot(u);
                    if (iss_valid[u] !== (slot[u] >= 0))
                    begin
                        $display("error %s: unit %0d issue_valid expected %0b actual %0b",
                                 cur_test, u, slot[u] >= 0, iss_valid[u]);
                        errors++;
                    end
                    else if (slot[u] >= 0 && issue_fields(u) !== expected_fields(u, slot[u]))
                    begin
                        $display("error %s: unit %0d issue fields expected %h actual %h",
                                 cur_test, u, expected_fields(u, slot[u]), issue_fields(u));
                        errors++;
                    end
                end
                u_in      = int'(dispatch_unit);
                free_slot = (u_in < 3) ? lowest_slot(u_in, ~m_occ[u_in]) : -1;
                exp_ready = (free_slot >= 0);
                if (dispatch_ready !== exp_ready)
                begin
                    $display("error %s: dispatch_ready expected %0b actual %0b",
                             cur_test, exp_ready, dispatch_ready);
                    errors++;
                end
                model_wakeup();
                for (int u = 0; u < 3; u++)
                begin
                    if (slot[u] >= 0 && iss_ready[u])
                        m_occ[u][slot[u]] = 1'b0;
                    if (iss_valid[u] && iss_ready[u])
                    begin
                        if (!live[iss_rob[u]])
                        begin
                            $display("%s: unit %0d issued rob %0d which no station was holding",
                                     cur_test, u, iss_rob[u]);
                            errors++;
                        end
                        live[iss_rob[u]] = 1'b0;
                        issued++;
                    end
                end
                if (dispatch_valid && dispatch_ready)
                begin
                    live[rob_idx] = 1'b1;
                    dispatched++;
                end
                if (dispatch_valid && free_slot >= 0)
                    model_insert(u_in, free_slot);   // slot chosen before this edge's issue
            end
        end
    end

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_at_start)
            tests_bad++;
        $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    endtask

    // new micro-op on the dispatch port with a rob index no station holds
    task automatic drive_uop(input int unit, input int s1, input int s2,
                             input logic r1, input logic r2);
        while (live[next_rob])
            next_rob = (next_rob + 1) % 64;
        dispatch_valid = 1'b1;
        dispatch_unit  = rs_pkg::rs_unit_e'(unit);
        src1_tag       = rs_pkg::ptag_t'(s1);
        src2_tag       = rs_pkg::ptag_t'(s2);
        src1_ready     = r1;
        src2_ready     = r2;
        dst_tag        = rs_pkg::ptag_t'($urandom);
        dst_areg       = rs_pkg::areg_t'($urandom);
        op             = rs_pkg::op_t'($urandom);
        rob_idx        = rs_pkg::rob_idx_t'(next_rob);
        next_rob       = (next_rob + 1) % 64;
    endtask

    // runs from a falling edge to the falling edge after the transfer
    task automatic send_uop(input int unit, input int s1, input int s2,
                            input logic r1, input logic r2);
        int waited;
        waited = 0;
        drive_uop(unit, s1, s2, r1, r2);
        #1;
        while (!dispatch_ready && waited < 50)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!dispatch_ready)
        begin
            $display("%s: dispatch to unit %0d was never accepted", cur_test, unit);
            errors++;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic test_reset();
        start_test("reset");
        for (int code = 0; code < 4; code++)
        begin
            @(negedge clk);
            dispatch_unit = rs_pkg::rs_unit_e'(code);
            #1;
            if (iss_valid !== 3'b000)
            begin
                $display("error %s: issue_valid expected 000 actual %b", cur_test, iss_valid);
                errors++;
            end
            if (dispatch_ready !== (code < 3))
            begin
                $display("error %s: dispatch_ready for code %0d expected %0b actual %0b",
                         cur_test, code, code < 3, dispatch_ready);
                errors++;
            end
        end
        finish_test();
    endtask

    task automatic test_direct_issue();
        start_test("direct_issue");
        for (int u = 0; u < 3; u++)
        begin
            @(negedge clk);
            send_uop(u, 5 + u, 9 + u, 1'b1, 1'b1);
            iss_ready[u] = 1'b1;
            #1;
            if (!iss_valid[u] || iss_rob[u] !== rob_idx)
            begin
                $display("error %s: unit %0d rob expected %0d actual %0d (valid %0b)",
                         cur_test, u, rob_idx, iss_rob[u], iss_valid[u]);
                errors++;
            end
            @(negedge clk);
            iss_ready[u] = 1'b0;
            #1;
            if (iss_valid[u])
            begin
                $display("%s: unit %0d still presents an entry after the handshake", cur_test, u);
                errors++;
            end
        end
        finish_test();
    endtask

    task automatic test_wakeup();
        start_test("wakeup");
        for (int b = 0; b < 3; b++)
        begin
            @(negedge clk);
            send_uop(b, 12 + b, 20, 1'b0, 1'b1);
            #1;
            if (iss_valid[b])
            begin
                $display("%s: unit %0d issued with an operand still waiting", cur_test, b);
                errors++;
            end
            @(negedge clk);
            cdb_valid[b] = 1'b1;
            cdb_tag[b]   = rs_pkg::ptag_t'(12 + b);
            iss_ready[b] = 1'b1;
            @(negedge clk);
            cdb_valid[b] = 1'b0;
            #1;
            if (!iss_valid[b])
            begin
                $display("%s: unit %0d did not issue after broadcast of tag %0d",
                         cur_test, b, 12 + b);
                errors++;
            end
            // broadcast on the next bus in the dispatch cycle itself
            @(negedge clk);
            cdb_valid[(b + 1) % 3] = 1'b1;
            cdb_tag[(b + 1) % 3]   = rs_pkg::ptag_t'(30 + b);
            send_uop(b, 20, 30 + b, 1'b1, 1'b0);
            cdb_valid[(b + 1) % 3] = 1'b0;
            #1;
            if (!iss_valid[b])
            begin
                $display("%s: unit %0d missed a broadcast in its dispatch cycle", cur_test, b);
                errors++;
            end
            @(negedge clk);
            iss_ready[b] = 1'b0;
        end
        finish_test();
    endtask

    task automatic test_backpressure();
        int waited;
        start_test("backpressure");
        for (int u = 0; u < 3; u++)
        begin
            for (int k = 0; k < unit_depth(u); k++)
            begin
                @(negedge clk);
                send_uop(u, k, k + 1, 1'b1, 1'b1);
            end
            #1;
            if (dispatch_ready)
            begin
                $display("%s: unit %0d is full but dispatch_ready stayed high", cur_test, u);
                errors++;
            end
            @(negedge clk);
            iss_ready[u] = 1'b1;
            #1;
            if (dispatch_ready)
            begin
                $display("%s: dispatch_ready rose before unit %0d issued", cur_test, u);
                errors++;
            end
            @(negedge clk);
            #1;
            if (!dispatch_ready)
            begin
                $display("%s: dispatch_ready low after the first issue of unit %0d", cur_test, u);
                errors++;
            end
            waited = 0;
            while (iss_valid[u] && waited < 20)
            begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (iss_valid[u])
            begin
                $display("%s: unit %0d did not drain", cur_test, u);
                errors++;
            end
            @(negedge clk);
            iss_ready[u] = 1'b0;
        end
        finish_test();
    endtask

    task automatic test_random();
        logic accepted;
        int   waited;
        start_test("random");
        accepted = 1'b1;
        for (int c = 0; c < random_cycles; c++)
        begin
            @(negedge clk);
            if (!dispatch_valid || accepted)   // fields held until the transfer
            begin
                if ($urandom_range(0, 1) != 0)
                    drive_uop($urandom_range(0, 2), $urandom_range(0, 15), $urandom_range(0, 15),
                              1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
                else
                    dispatch_valid = 1'b0;
            end
            for (int b = 0; b < 3; b++)
            begin
                cdb_valid[b] = ($urandom_range(0, 2) == 0);
                cdb_tag[b]   = rs_pkg::ptag_t'($urandom_range(0, 15));
            end
            iss_ready = 3'($urandom);
            #1;
            accepted = dispatch_valid && dispatch_ready;
        end
        // drain with every tag swept across the buses
        @(negedge clk);
        iss_ready = 3'b111;
        waited    = 0;
        while ((dispatch_valid || dispatched != issued) && waited < drain_cycles)
        begin
            if (accepted)
                dispatch_valid = 1'b0;   // a pending micro-op waits for its transfer
            for (int b = 0; b < 3; b++)
            begin
                cdb_valid[b] = 1'b1;
                cdb_tag[b]   = rs_pkg::ptag_t'((3 * waited + b) % 64);
            end
            #1;
            accepted = dispatch_valid && dispatch_ready;
            @(negedge clk);
            waited++;
        end
        cdb_valid = 3'b000;
        if (dispatched != issued)
        begin
            $display("%s: %0d micro-ops dispatched but %0d issued", cur_test, dispatched, issued);
            errors++;
        end
        finish_test();
    endtask

    initial
    begin
        void'($urandom(32'h53e0d5c2));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_unit  = rs_pkg::UNIT_ADD;
        src1_tag       = '0;
        src2_tag       = '0;
        src1_ready     = 1'b0;
        src2_ready     = 1'b0;
        dst_tag        = '0;
        dst_areg       = '0;
        rob_idx        = '0;
        op             = '0;
        cdb_valid      = 3'b000;
        iss_ready      = 3'b000;
        for (int b = 0; b < 3; b++)
            cdb_tag[b] = '0;
        for (int i = 0; i < 64; i++)
            live[i] = 1'b0;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        dispatched = 0;
        issued     = 0;
        next_rob   = 0;
        cur_test   = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_direct_issue();
        test_wakeup();
        test_backpressure();
        test_random();
        $display("summary: %0d run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: logic/reservation_stations.sv
module reservation_stations (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    output logic                dispatch_ready,
    input  rs_pkg::rs_unit_e    dispatch_unit,
    input  rs_pkg::ptag_t       src1_tag,
    input  rs_pkg::ptag_t       src2_tag,
    input  logic                src1_ready,
    input  logic                src2_ready,
    input  rs_pkg::ptag_t       dst_tag,
    input  rs_pkg::areg_t       dst_areg,
    input  rs_pkg::rob_idx_t    rob_idx,
    input  rs_pkg::op_t         op,
    input  logic                cdb_valid_add,
    input  rs_pkg::ptag_t       cdb_tag_add,
    input  logic                cdb_valid_mul,
    input  rs_pkg::ptag_t       cdb_tag_mul,
    input  logic                cdb_valid_div,
    input  rs_pkg::ptag_t       cdb_tag_div,
    output logic                add_issue_valid,
    input  logic                add_issue_ready,
    output rs_pkg::ptag_t       add_src1_tag,
    output rs_pkg::ptag_t       add_src2_tag,
    output rs_pkg::ptag_t       add_dst_tag,
    output rs_pkg::areg_t       add_dst_areg,
    output rs_pkg::rob_idx_t    add_rob_idx,
    output rs_pkg::op_t         add_op,
    output logic                mul_issue_valid,
    input  logic                mul_issue_ready,
    output rs_pkg::ptag_t       mul_src1_tag,
    output rs_pkg::ptag_t       mul_src2_tag,
    output rs_pkg::ptag_t       mul_dst_tag,
    output rs_pkg::areg_t       mul_dst_areg,
    output rs_pkg::rob_idx_t    mul_rob_idx,
    output rs_pkg::op_t         mul_op,
    output logic                div_issue_valid,
    input  logic                div_issue_ready,
    output rs_pkg::ptag_t       div_src1_tag,
    output rs_pkg::ptag_t       div_src2_tag,
    output rs_pkg::ptag_t       div_dst_tag,
    output rs_pkg::areg_t       div_dst_areg,
    output rs_pkg::rob_idx_t    div_rob_idx,
    output rs_pkg::op_t         div_op
);

    logic [2:0] sel;            // one-hot add, mul, div
    logic [2:0] station_ready;
    logic [2:0] insert_valid;

    always_comb
    begin
        sel = 3'b000;
        case (dispatch_unit)
            rs_pkg::UNIT_ADD: sel = 3'b001;
            rs_pkg::UNIT_MUL: sel = 3'b010;
            rs_pkg::UNIT_DIV: sel = 3'b100;
            default:          sel = 3'b000;  // code 3 goes nowhere
        endcase
    end

    assign dispatch_ready = |(sel & station_ready);
    assign insert_valid   = {3{dispatch_valid}} & sel & station_ready;

    rs_station #(.depth(rs_pkg::ADD_RS_DEPTH)) add_rs (
        .clk (clk), .rst (rst),
        .insert_valid (insert_valid[0]), .insert_ready (station_ready[0]),
        .src1_tag (src1_tag), .src2_tag (src2_tag),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .dst_tag (dst_tag), .dst_areg (dst_areg), .rob_idx (rob_idx), .op (op),
        .cdb_valid_add (cdb_valid_add), .cdb_tag_add (cdb_tag_add),
        .cdb_valid_mul (cdb_valid_mul), .cdb_tag_mul (cdb_tag_mul),
        .cdb_valid_div (cdb_valid_div), .cdb_tag_div (cdb_tag_div),
        .issue_valid (add_issue_valid), .issue_ready (add_issue_ready),
        .issue_src1_tag (add_src1_tag), .issue_src2_tag (add_src2_tag),
        .issue_dst_tag (add_dst_tag), .issue_dst_areg (add_dst_areg),
        .issue_rob_idx (add_rob_idx), .issue_op (add_op)
    );

    rs_station #(.depth(rs_pkg::MUL_RS_DEPTH)) mul_rs (
        .clk (clk), .rst (rst),
        .insert_valid (insert_valid[1]), .insert_ready (station_ready[1]),
        .src1_tag (src1_tag), .src2_tag (src2_tag),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .dst_tag (dst_tag), .dst_areg (dst_areg), .rob_idx (rob_idx), .op (op),
        .cdb_valid_add (cdb_valid_add), .cdb_tag_add (cdb_tag_add),
        .cdb_valid_mul (cdb_valid_mul), .cdb_tag_mul (cdb_tag_mul),
        .cdb_valid_div (cdb_valid_div), .cdb_tag_div (cdb_tag_div),
        .issue_valid (mul_issue_valid), .issue_ready (mul_issue_ready),
        .issue_src1_tag (mul_src1_tag), .issue_src2_tag (mul_src2_tag),
        .issue_dst_tag (mul_dst_tag), .issue_dst_areg (mul_dst_areg),
        .issue_rob_idx (mul_rob_idx), .issue_op (mul_op)
    );

    rs_station #(.depth(rs_pkg::DIV_RS_DEPTH)) div_rs (
        .clk (clk), .rst (rst),
        .insert_valid (insert_valid[2]), .insert_ready (station_ready[2]),
        .src1_tag (src1_tag), .src2_tag (src2_tag),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .dst_tag (dst_tag), .dst_areg (dst_areg), .rob_idx (rob_idx), .op (op),
        .cdb_valid_add (cdb_valid_add), .cdb_tag_add (cdb_tag_add),
        .cdb_valid_mul (cdb_valid_mul), .cdb_tag_mul (cdb_tag_mul),
        .cdb_valid_div (cdb_valid_div), .cdb_tag_div (cdb_tag_div),
        .issue_valid (div_issue_valid), .issue_ready (div_issue_ready),
        .issue_src1_tag (div_src1_tag), .issue_src2_tag (div_src2_tag),
        .issue_dst_tag (div_dst_tag), .issue_dst_areg (div_dst_areg),
        .issue_rob_idx (div_rob_idx), .issue_op (div_op)
    );

endmodule

// File: station/rs_station.sv
module rs_station #(
    parameter int depth = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               insert_valid,
    output logic               insert_ready,
    input  rs_pkg::ptag_t      src1_tag,
    input  rs_pkg::ptag_t      src2_tag,
    input  logic               src1_ready,
    input  logic               src2_ready,
    input  rs_pkg::ptag_t      dst_tag,
    input  rs_pkg::areg_t      dst_areg,
    input  rs_pkg::rob_idx_t   rob_idx,
    input  rs_pkg::op_t        op,
    input  logic               cdb_valid_add,
    input  rs_pkg::ptag_t      cdb_tag_add,
    input  logic               cdb_valid_mul,
    input  rs_pkg::ptag_t      cdb_tag_mul,
    input  logic               cdb_valid_div,
    input  rs_pkg::ptag_t      cdb_tag_div,
    output logic               issue_valid,
    input  logic               issue_ready,
    output rs_pkg::ptag_t      issue_src1_tag,
    output rs_pkg::ptag_t      issue_src2_tag,
    output rs_pkg::ptag_t      issue_dst_tag,
    output rs_pkg::areg_t      issue_dst_areg,
    output rs_pkg::rob_idx_t   issue_rob_idx,
    output rs_pkg::op_t        issue_op
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    logic [depth-1:0] occupied;
    logic [depth-1:0] rdy1;
    logic [depth-1:0] rdy2;

    // entry fields
    rs_pkg::ptag_t    src1_q [depth];
    rs_pkg::ptag_t    src2_q [depth];
    rs_pkg::ptag_t    dst_q  [depth];
    rs_pkg::areg_t    areg_q [depth];
    rs_pkg::rob_idx_t rob_q  [depth];
    rs_pkg::op_t      op_q   [depth];

    logic [depth-1:0] hit1;
    logic [depth-1:0] hit2;
    logic             new_hit1;
    logic             new_hit2;
    logic [depth-1:0] ready_both;
    logic             free_found;
    logic             issue_found;
    logic [idx_w-1:0] free_idx;
    logic [idx_w-1:0] issue_idx;
    logic             do_insert;
    logic             do_issue;

    rs_wakeup #(.depth(depth)) wakeup (
        .stored_src1_tag (src1_q),
        .stored_src2_tag (src2_q),
        .new_src1_tag    (src1_tag),
        .new_src2_tag    (src2_tag),
        .cdb_valid_add   (cdb_valid_add),
        .cdb_tag_add     (cdb_tag_add),
        .cdb_valid_mul   (cdb_valid_mul),
        .cdb_tag_mul     (cdb_tag_mul),
        .cdb_valid_div   (cdb_valid_div),
        .cdb_tag_div     (cdb_tag_div),
        .hit1            (hit1),
        .hit2            (hit2),
        .new_hit1        (new_hit1),
        .new_hit2        (new_hit2)
    );

    assign ready_both = rdy1 & rdy2;

    rs_slot_picker #(.depth(depth)) picker (
        .occupied    (occupied),
        .ready_both  (ready_both),
        .free_found  (free_found),
        .free_idx    (free_idx),
        .issue_found (issue_found),
        .issue_idx   (issue_idx)
    );

    assign insert_ready = free_found;   // full when nothing is free
    assign do_insert    = insert_valid && free_found;
    assign issue_valid  = issue_found;
    assign do_issue     = issue_found && issue_ready;

    assign issue_src1_tag = src1_q[issue_idx];
    assign issue_src2_tag = src2_q[issue_idx];
    assign issue_dst_tag  = dst_q[issue_idx];
    assign issue_dst_areg = areg_q[issue_idx];
    assign issue_rob_idx  = rob_q[issue_idx];
    assign issue_op       = op_q[issue_idx];

    // free slot and issue slot never coincide, so both updates can land together
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            occupied <= '0;
        end
        else
        begin
            if (do_insert)
                occupied[free_idx] <= 1'b1;
            if (do_issue)
                occupied[issue_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        rdy1 <= rdy1 | (hit1 & occupied);
        rdy2 <= rdy2 | (hit2 & occupied);
        if (do_insert)
        begin
            rdy1[free_idx] <= src1_ready | new_hit1;   // same-cycle broadcast counts
            rdy2[free_idx] <= src2_ready | new_hit2;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_insert)
        begin
            src1_q[free_idx] <= src1_tag;
            src2_q[free_idx] <= src2_tag;
            dst_q[free_idx]  <= dst_tag;
            areg_q[free_idx] <= dst_areg;
            rob_q[free_idx]  <= rob_idx;
            op_q[free_idx]   <= op;
        end
    end

    // picker result has to agree with the occupancy held here
    insert_slot_free: assert property (@(posedge clk) disable iff (rst)
        do_insert |-> !occupied[free_idx]);

    issue_slot_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> occupied[issue_idx] && rdy1[issue_idx] && rdy2[issue_idx]);

    // the top only raises insert_valid on an accepted dispatch
    no_insert_when_full: assert property (@(posedge clk) disable iff (rst)
        insert_valid |-> insert_ready);

endmodule

// File: station/rs_slot_picker.sv
module rs_slot_picker #(
    parameter int depth = 4
) (
    input  logic [depth-1:0] occupied,
    input  logic [depth-1:0] ready_both,
    output logic             free_found,
    output logic [((depth > 1) ? $clog2(depth) : 1)-1:0] free_idx,
    output logic             issue_found,
    output logic [((depth > 1) ? $clog2(depth) : 1)-1:0] issue_idx
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    // walk from the top so the lowest hit is the one left standing
    always_comb
    begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = depth - 1; i >= 0; i--)
        begin
            if (!occupied[i])
            begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
        end
    end

    always_comb
    begin
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = depth - 1; i >= 0; i--)
        begin
            if (occupied[i] && ready_both[i])
            begin
                issue_found = 1'b1;
                issue_idx   = idx_w'(i);
            end
        end
    end

endmodule

// File: station/rs_wakeup.sv
module rs_wakeup #(
    parameter int depth = 4
) (
    input  rs_pkg::ptag_t    stored_src1_tag [depth],
    input  rs_pkg::ptag_t    stored_src2_tag [depth],
    input  rs_pkg::ptag_t    new_src1_tag,
    input  rs_pkg::ptag_t    new_src2_tag,
    input  logic             cdb_valid_add,
    input  rs_pkg::ptag_t    cdb_tag_add,
    input  logic             cdb_valid_mul,
    input  rs_pkg::ptag_t    cdb_tag_mul,
    input  logic             cdb_valid_div,
    input  rs_pkg::ptag_t    cdb_tag_div,
    output logic [depth-1:0] hit1,
    output logic [depth-1:0] hit2,
    output logic             new_hit1,
    output logic             new_hit2
);

    // true when any live broadcast carries this tag
    function automatic logic bcast_match(
        input rs_pkg::ptag_t tag,
        input logic          v_add,
        input rs_pkg::ptag_t t_add,
        input logic          v_mul,
        input rs_pkg::ptag_t t_mul,
        input logic          v_div,
        input rs_pkg::ptag_t t_div
    );
        bcast_match = (v_add && (tag == t_add))
                   || (v_mul && (tag == t_mul))
                   || (v_div && (tag == t_div));
    endfunction

    always_comb
    begin
        for (int i = 0; i < depth; i++)
        begin
            hit1[i] = bcast_match(stored_src1_tag[i], cdb_valid_add, cdb_tag_add,
                                  cdb_valid_mul, cdb_tag_mul, cdb_valid_div, cdb_tag_div);
            hit2[i] = bcast_match(stored_src2_tag[i], cdb_valid_add, cdb_tag_add,
                                  cdb_valid_mul, cdb_tag_mul, cdb_valid_div, cdb_tag_div);
        end
        // operands of the micro-op arriving this cycle
        new_hit1 = bcast_match(new_src1_tag, cdb_valid_add, cdb_tag_add,
                               cdb_valid_mul, cdb_tag_mul, cdb_valid_div, cdb_tag_div);
        new_hit2 = bcast_match(new_src2_tag, cdb_valid_add, cdb_tag_add,
                               cdb_valid_mul, cdb_tag_mul, cdb_valid_div, cdb_tag_div);
    end

endmodule

// File: common/rs_pkg.sv
package rs_pkg;

    // field widths
    localparam int PTAG_W = 6;     // 64 physical registers
    localparam int AREG_W = 5;     // rv32 register file
    localparam int ROB_W  = 6;
    localparam int OP_W   = 4;

    typedef logic [PTAG_W-1:0] ptag_t;
    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [OP_W-1:0]   op_t;

    // dispatch steering, code 3 selects no station
    typedef enum logic [1:0] {
        UNIT_ADD = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } rs_unit_e;

    // station sizes
    localparam int ADD_RS_DEPTH = 8;
    localparam int MUL_RS_DEPTH = 4;
    localparam int DIV_RS_DEPTH = 4;

endpackage
